//--- logic/pong_pkg.sv
package pong_pkg;

        // ====================================================================
        // coordinate widths and screen geometry
        // ====================================================================

        // x runs 0 to 159 and y runs 0 to 119 on the 160x120 screen
        localparam int X_W = 8;
        localparam int Y_W = 7;

        localparam logic [X_W-1:0] SCREEN_W = 160;
        localparam logic [Y_W-1:0] SCREEN_H = 120;

        // the red frame sits on these lines and the bottom stays open
        localparam logic [X_W-1:0] LEFT_LINE  = 5;
        localparam logic [X_W-1:0] RIGHT_LINE = 154;
        localparam logic [Y_W-1:0] TOP_LINE   = 5;

        // the paddle covers x through x + PADDLE_WIDTH, so it is one pixel wider
        // than the width suggests
        localparam logic [Y_W-1:0] PADDLE_ROW     = 110;
        localparam logic [X_W-1:0] PADDLE_WIDTH   = 20;
        localparam logic [X_W-1:0] PADDLE_X_START = 70;
        localparam logic [X_W-1:0] PADDLE_STEP    = 2;

        // limits on the left edge of the paddle before a move is allowed
        localparam logic [X_W-1:0] PADDLE_X_MAX = RIGHT_LINE - PADDLE_WIDTH - 2;
        localparam logic [X_W-1:0] PADDLE_X_MIN = LEFT_LINE + 2;

        // the puck turns round on the pixel next to a wall, or just above the paddle
        localparam logic [X_W-1:0] BOUNCE_LEFT_X  = LEFT_LINE + 1;
        localparam logic [X_W-1:0] BOUNCE_RIGHT_X = RIGHT_LINE - 1;
        localparam logic [Y_W-1:0] BOUNCE_TOP_Y   = TOP_LINE + 1;
        localparam logic [Y_W-1:0] HIT_ROW_Y      = PADDLE_ROW - 1;

        localparam logic [X_W-1:0] FACEOFF_X = 80;
        localparam logic [Y_W-1:0] FACEOFF_Y = 60;
        localparam logic signed [1:0] VEL_START_X = 2'sd1;
        localparam logic signed [1:0] VEL_START_Y = -2'sd1;

        // an eighth of a second at 50 MHz
        localparam int FRAME_CYCLES = 6_250_000;

        // colours are {r, g, b}, one bit each
        localparam logic [2:0] BLACK = 3'b000;
        localparam logic [2:0] RED   = 3'b100;
        localparam logic [2:0] CYAN  = 3'b011;

        // ====================================================================
        // shared types
        // ====================================================================

        typedef struct packed {
                logic [X_W-1:0] x;
                logic [Y_W-1:0] y;
        } point_t;

        // each component is always +1 or -1
        typedef struct packed {
                logic signed [1:0] dx;
                logic signed [1:0] dy;
        } velocity_t;

        // one pixel write
        typedef struct packed {
                logic [X_W-1:0] x;
                logic [Y_W-1:0] y;
                logic [2:0]     colour;
        } pixel_t;

endpackage

//--- logic/frame_timer.sv
`timescale 1ns/10ps

module frame_timer #(
        parameter int frame_cycles = pong_pkg::FRAME_CYCLES
) (
        input  logic       CLOCK_50,
        input  logic [3:0] KEY,
        input  logic       start,
        output logic       expired
);

        // the counter is loaded with frame_cycles - 1 so that it hits zero
        // exactly frame_cycles cycles after the start pulse
        logic [$clog2(frame_cycles)-1:0] count;
        logic                            armed;

        always_ff @(posedge CLOCK_50 or negedge KEY[3]) begin
                if (!KEY[3]) begin
                        armed <= 1'b0;
                        count <= '0;
                end else if (start) begin
                        armed <= 1'b1;
                        count <= $clog2(frame_cycles)'(frame_cycles - 1);
                end else if (armed) begin
                        // disarm on the expiring cycle so the pulse lasts one clock
                        if (count == '0)
                                armed <= 1'b0;
                        else
                                count <= count - 1'b1;
                end
        end

        assign expired = armed && (count == '0);

endmodule

//--- logic/pixel_walker.sv
`timescale 1ns/10ps

module pixel_walker (
        input  logic                      CLOCK_50,
        input  logic [3:0]                KEY,
        input  logic                      start,
        input  pong_pkg::point_t          origin,
        input  logic                      vertical,
        input  logic [pong_pkg::X_W-1:0]  stop,
        input  logic [2:0]                colour,
        output pong_pkg::pixel_t          pixel,
        output logic                      plot,
        output logic                      done
);

        import pong_pkg::*;

        logic           vertical_q;
        logic [X_W-1:0] stop_q;
        logic [X_W-1:0] along;

        // the coordinate that moves along the run, widened to compare with stop
        assign along = vertical_q ? X_W'(pixel.y) : pixel.x;

        // done marks the last pixel of the run while it is on the output
        assign done = plot && (along == stop_q);

        // ====================================================================
        // run control
        // ====================================================================

        always_ff @(posedge CLOCK_50 or negedge KEY[3]) begin
                if (!KEY[3])
                        plot <= 1'b0;
                else if (start)
                        plot <= 1'b1;
                else if (done)
                        plot <= 1'b0;
        end

        // the run is latched on start, then the moving coordinate counts up
        // one pixel per cycle while the other one holds
        always_ff @(posedge CLOCK_50) begin
                if (start) begin
                        pixel      <= '{x: origin.x, y: origin.y, colour: colour};
                        vertical_q <= vertical;
                        stop_q     <= stop;
                end else if (plot && !done) begin
                        if (vertical_q)
                                pixel.y <= pixel.y + 1'b1;
                        else
                                pixel.x <= pixel.x + 1'b1;
                end
        end

endmodule

//--- logic/paddle_unit.sv
`timescale 1ns/10ps

module paddle_unit (
        input  logic                      CLOCK_50,
        input  logic [3:0]                KEY,
        input  logic                      move,
        input  logic                      restart,
        output logic [pong_pkg::X_W-1:0]  paddle_x
);

        import pong_pkg::*;

        // paddle_x is the left-most pixel of the paddle
        always_ff @(posedge CLOCK_50 or negedge KEY[3]) begin
                if (!KEY[3]) begin
                        paddle_x <= PADDLE_X_START;
                end else if (restart) begin
                        paddle_x <= PADDLE_X_START;
                end else if (move) begin
                        // KEY[0] pressed means go right, and it masks KEY[1] even
                        // when the paddle is already against the right side
                        if (!KEY[0]) begin
                                if (paddle_x <= PADDLE_X_MAX)
                                        paddle_x <= paddle_x + PADDLE_STEP;
                        end else if (!KEY[1] && paddle_x >= PADDLE_X_MIN) begin
                                paddle_x <= paddle_x - PADDLE_STEP;
                        end
                end
        end

endmodule

//--- logic/puck_unit.sv
`timescale 1ns/10ps

module puck_unit (
        input  logic                      CLOCK_50,
        input  logic [3:0]                KEY,
        input  logic                      step,
        input  logic                      restart,
        input  logic [pong_pkg::X_W-1:0]  paddle_x,
        output pong_pkg::point_t          puck,
        output pong_pkg::point_t          prev,
        output logic                      miss
);

        import pong_pkg::*;

        velocity_t      vel;
        logic [X_W-1:0] next_x;
        logic [Y_W-1:0] next_y;
        logic           on_row;
        logic           on_paddle;

        // ====================================================================
        // next position and the tests made on it
        // ====================================================================

        // velocity components are sign extended onto the coordinates
        assign next_x = puck.x + {{(X_W-2){vel.dx[1]}}, vel.dx};
        assign next_y = puck.y + {{(Y_W-2){vel.dy[1]}}, vel.dy};

        // the row just above the paddle is where the puck is either
        // returned or lost
        assign on_row    = (next_y == HIT_ROW_Y);
        assign on_paddle = (next_x >= paddle_x) && (next_x <= paddle_x + PADDLE_WIDTH);

        always_ff @(posedge CLOCK_50 or negedge KEY[3]) begin
                if (!KEY[3]) begin
                        puck <= '{x: FACEOFF_X, y: FACEOFF_Y};
                        vel  <= '{dx: VEL_START_X, dy: VEL_START_Y};
                        miss <= 1'b0;
                end else if (restart) begin
                        puck <= '{x: FACEOFF_X, y: FACEOFF_Y};
                        vel  <= '{dx: VEL_START_X, dy: VEL_START_Y};
                        miss <= 1'b0;
                end else if (step) begin
                        puck <= '{x: next_x, y: next_y};
                        // top wall and paddle both send the puck back vertically
                        if (next_y == BOUNCE_TOP_Y || (on_row && on_paddle))
                                vel.dy <= -vel.dy;
                        if (next_x == BOUNCE_LEFT_X || next_x == BOUNCE_RIGHT_X)
                                vel.dx <= -vel.dx;
                        miss <= on_row && !on_paddle;
                end
        end

        // prev is the spot the sequencer erases after each step
        always_ff @(posedge CLOCK_50) begin
                if (step)
                        prev <= puck;
        end

endmodule

//--- logic/draw_sequencer.sv
`timescale 1ns/10ps

module draw_sequencer (
        input  logic                      CLOCK_50,
        input  logic [3:0]                KEY,
        input  logic                      done,
        input  logic                      expired,
        input  logic [pong_pkg::X_W-1:0]  paddle_x,
        input  pong_pkg::point_t          puck,
        input  pong_pkg::point_t          prev,
        input  logic                      miss,
        output logic                      start,
        output pong_pkg::point_t          origin,
        output logic                      vertical,
        output logic [pong_pkg::X_W-1:0]  stop,
        output logic [2:0]                colour,
        output logic                      timer_start,
        output logic                      move,
        output logic                      step,
        output logic                      restart
);

        import pong_pkg::*;

        // each drawing state launches one walker run and hands over to
        // S_WAIT, which returns to the state held in after once done shows
        typedef enum logic [3:0] {
                S_RESTART, S_CLEAR, S_TOP, S_RIGHT, S_LEFT, S_ARM, S_IDLE,
                S_ERASE_PAD, S_MOVE, S_DRAW_PAD, S_STEP, S_ERASE_PUCK,
                S_DRAW_PUCK, S_WAIT
        } state_t;

        state_t         state;
        state_t         after;
        state_t         next_after;
        logic [Y_W-1:0] row_cnt;

        // ====================================================================
        // run selection
        // ====================================================================

        always_comb begin
                start       = 1'b0;
                origin      = '{x: '0, y: '0};
                vertical    = 1'b0;
                stop        = '0;
                colour      = BLACK;
                next_after  = S_ARM;
                timer_start = 1'b0;
                move        = 1'b0;
                step        = 1'b0;
                restart     = 1'b0;
                case (state)
                        S_RESTART: restart = 1'b1;
                        S_CLEAR: begin
                                // one black row per run, the last one leads on to the frame
                                start      = 1'b1;
                                origin     = '{x: '0, y: row_cnt};
                                stop       = SCREEN_W - 1'b1;
                                next_after = (row_cnt == SCREEN_H - 1'b1) ? S_TOP : S_CLEAR;
                        end
                        S_TOP: begin
                                start      = 1'b1;
                                origin     = '{x: LEFT_LINE, y: TOP_LINE};
                                stop       = RIGHT_LINE;
                                colour     = RED;
                                next_after = S_RIGHT;
                        end
                        S_RIGHT, S_LEFT: begin
                                start      = 1'b1;
                                origin     = '{x: (state == S_RIGHT) ? RIGHT_LINE : LEFT_LINE,
                                               y: TOP_LINE};
                                vertical   = 1'b1;
                                stop       = X_W'(SCREEN_H - 1'b1);
                                colour     = RED;
                                next_after = (state == S_RIGHT) ? S_LEFT : S_ARM;
                        end
                        S_ARM:  timer_start = 1'b1;
                        S_ERASE_PAD, S_DRAW_PAD: begin
                                // paddle_x has already moved by the time S_DRAW_PAD runs
                                start      = 1'b1;
                                origin     = '{x: paddle_x, y: PADDLE_ROW};
                                stop       = paddle_x + PADDLE_WIDTH;
                                colour     = (state == S_DRAW_PAD) ? RED : BLACK;
                                next_after = (state == S_DRAW_PAD) ? S_STEP : S_MOVE;
                        end
                        S_MOVE: move = 1'b1;
                        S_STEP: step = 1'b1;
                        S_ERASE_PUCK: begin
                                // a miss skips the cyan pixel and goes straight to a restart
                                start      = 1'b1;
                                origin     = prev;
                                stop       = prev.x;
                                next_after = miss ? S_RESTART : S_DRAW_PUCK;
                        end
                        S_DRAW_PUCK: begin
                                start  = 1'b1;
                                origin = puck;
                                stop   = puck.x;
                                colour = CYAN;
                        end
                        default: ;
                endcase
        end

        // ====================================================================
        // state register
        // ====================================================================

        // reset enters through S_RESTART, so the first clear takes the same path
        // as the one after a missed puck
        always_ff @(posedge CLOCK_50 or negedge KEY[3]) begin
                if (!KEY[3]) begin
                        state   <= S_RESTART;
                        after   <= S_CLEAR;
                        row_cnt <= '0;
                end else begin
                        if (start) begin
                                state <= S_WAIT;
                                after <= next_after;
                        end
                        case (state)
                                S_RESTART: begin
                                        row_cnt <= '0;
                                        state   <= S_CLEAR;
                                end
                                S_CLEAR: row_cnt <= row_cnt + 1'b1;
                                S_ARM:   state <= S_IDLE;
                                S_IDLE: begin
                                        if (expired)
                                                state <= S_ERASE_PAD;
                                end
                                S_MOVE:  state <= S_DRAW_PAD;
                                S_STEP:  state <= S_ERASE_PUCK;
                                S_WAIT: begin
                                        // plot is low for the cycle after done, which
                                        // keeps a gap between runs
                                        if (done)
                                                state <= after;
                                end
                                default: ;
                        endcase
                end
        end

endmodule

//--- logic/pong_top.sv
`timescale 1ns/10ps

module pong_top #(
        parameter int frame_cycles = pong_pkg::FRAME_CYCLES
) (
        input  logic             CLOCK_50,
        input  logic [3:0]       KEY,
        output pong_pkg::pixel_t pixel,
        output logic             plot
);

        import pong_pkg::*;

        // walker run request from the sequencer
        logic           start;
        point_t         origin;
        logic           vertical;
        logic [X_W-1:0] stop;
        logic [2:0]     colour;
        logic           done;

        // frame pacing and game state
        logic           timer_start;
        logic           expired;
        logic           move;
        logic           step;
        logic           restart;
        logic [X_W-1:0] paddle_x;
        point_t         puck;
        point_t         prev;
        logic           miss;

        draw_sequencer i_seq (
                .CLOCK_50    (CLOCK_50),
                .KEY         (KEY),
                .done        (done),
                .expired     (expired),
                .paddle_x    (paddle_x),
                .puck        (puck),
                .prev        (prev),
                .miss        (miss),
                .start       (start),
                .origin      (origin),
                .vertical    (vertical),
                .stop        (stop),
                .colour      (colour),
                .timer_start (timer_start),
                .move        (move),
                .step        (step),
                .restart     (restart)
        );

        frame_timer #(
                .frame_cycles (frame_cycles)
        ) i_timer (
                .CLOCK_50 (CLOCK_50),
                .KEY      (KEY),
                .start    (timer_start),
                .expired  (expired)
        );

        pixel_walker i_walker (
                .CLOCK_50 (CLOCK_50),
                .KEY      (KEY),
                .start    (start),
                .origin   (origin),
                .vertical (vertical),
                .stop     (stop),
                .colour   (colour),
                .pixel    (pixel),
                .plot     (plot),
                .done     (done)
        );

        paddle_unit i_paddle (
                .CLOCK_50 (CLOCK_50),
                .KEY      (KEY),
                .move     (move),
                .restart  (restart),
                .paddle_x (paddle_x)
        );

        puck_unit i_puck (
                .CLOCK_50 (CLOCK_50),
                .KEY      (KEY),
                .step     (step),
                .restart  (restart),
                .paddle_x (paddle_x),
                .puck     (puck),
                .prev     (prev),
                .miss     (miss)
        );

endmodule

//--- bench/pong_tb.sv
`timescale 1ns/10ps

module pong_tb;

        import pong_pkg::*;

        // a short frame keeps the idle gap between game frames small
        localparam int FRAME_LEN    = 40;
        localparam int IDLE_LIMIT   = 500;
        localparam int MIN_FRAMES   = 150;
        localparam int FRAMES_AFTER = 20;
        localparam int MAX_FRAMES   = 3000;

        logic        CLOCK_50;
        logic [3:0]  KEY;
        pixel_t      pixel;
        logic        plot;

        // pixels the model expects, in the order the DUT should plot them
        pixel_t      expected[$];

        // model of the game state, all in whole pixels
        int          paddle_x;
        int          puck_x;
        int          puck_y;
        int          prev_x;
        int          prev_y;
        int          dx;
        int          dy;
        bit          missed;
        int          misses;
        int          since_miss;
        int          frames;

        // paddle returns and blocked moves seen during the run
        int          paddle_hits;
        int          game_hits;
        int          right_stops;
        int          left_stops;

        pong_top #(
                .frame_cycles (FRAME_LEN)
        ) i_dut (
                .CLOCK_50 (CLOCK_50),
                .KEY      (KEY),
                .pixel    (pixel),
                .plot     (plot)
        );

        initial begin
                CLOCK_50 = 1'b0;
                forever #10 CLOCK_50 = ~CLOCK_50;
        end

        // ====================================================================
        // checking and pixel stream tracking
        // ====================================================================

        task automatic stop_on_error(input string why);
                $display("error: %s", why);
                $display("FAIL: see errors above");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
                if (act !== exp) begin
                        $display("Mismatch %s: expected (%0d,%0d,%b), actual (%0d,%0d,%b)",
                                 name, exp.x, exp.y, exp.colour, act.x, act.y, act.colour);
                        stop_on_error("pixel stream differs from the model");
                end
        endtask

        // a run counts up along x, or along y when vertical, through stop inclusive
        task automatic queue_run(input int x0, input int y0, input bit vertical,
                                 input int stop, input logic [2:0] colour);
                pixel_t p;
                int     first;
                first = vertical ? y0 : x0;
                for (int i = first; i <= stop; i++) begin
                        p.x      = X_W'(vertical ? x0 : i);
                        p.y      = Y_W'(vertical ? i : y0);
                        p.colour = colour;
                        expected.push_back(p);
                end
        endtask

        // outputs are sampled on the falling edge, half a cycle after they change
        task automatic wait_for_pixels(input string name);
                int idle;
                idle = 0;
                while (expected.size() > 0) begin
                        @(negedge CLOCK_50);
                        if (plot) begin
                                check_pixel(name, expected.pop_front(), pixel);
                                idle = 0;
                        end else begin
                                idle++;
                                if (idle > IDLE_LIMIT)
                                        stop_on_error($sformatf("timeout, the %s pixels never came",
                                                                name));
                        end
                end
        endtask

        // ====================================================================
        // game model
        // ====================================================================

        task automatic reset_model();
                paddle_x  = int'(PADDLE_X_START);
                puck_x    = int'(FACEOFF_X);
                puck_y    = int'(FACEOFF_Y);
                dx        = int'(VEL_START_X);
                dy        = int'(VEL_START_Y);
                missed    = 1'b0;
                game_hits = 0;
        endtask

        // the clear runs row by row, then the frame goes top, right, left
        task automatic draw_screen();
                for (int row = 0; row < int'(SCREEN_H); row++)
                        queue_run(0, row, 1'b0, int'(SCREEN_W) - 1, BLACK);
                wait_for_pixels("screen clear");
                queue_run(int'(LEFT_LINE), int'(TOP_LINE), 1'b0, int'(RIGHT_LINE), RED);
                wait_for_pixels("top line");
                queue_run(int'(RIGHT_LINE), int'(TOP_LINE), 1'b1, int'(SCREEN_H) - 1, RED);
                wait_for_pixels("right line");
                queue_run(int'(LEFT_LINE), int'(TOP_LINE), 1'b1, int'(SCREEN_H) - 1, RED);
                wait_for_pixels("left line");
        endtask

        // a pressed KEY[0] takes priority even when the paddle cannot go right
        task automatic move_paddle_model();
                if (!KEY[0]) begin
                        if (paddle_x <= int'(RIGHT_LINE) - int'(PADDLE_WIDTH) - 2)
                                paddle_x = paddle_x + int'(PADDLE_STEP);
                        else
                                right_stops++;
                end else if (!KEY[1]) begin
                        if (paddle_x >= int'(LEFT_LINE) + 2)
                                paddle_x = paddle_x - int'(PADDLE_STEP);
                        else
                                left_stops++;
                end
        endtask

        task automatic step_puck_model();
                bit on_row;
                bit on_paddle;
                prev_x    = puck_x;
                prev_y    = puck_y;
                puck_x    = puck_x + dx;
                puck_y    = puck_y + dy;
                on_row    = (puck_y == int'(PADDLE_ROW) - 1);
                on_paddle = (puck_x >= paddle_x) && (puck_x <= paddle_x + int'(PADDLE_WIDTH));
                // the paddle returns the puck just like the top wall does
                if (puck_y == int'(TOP_LINE) + 1 || (on_row && on_paddle))
                        dy = -dy;
                if (puck_x == int'(LEFT_LINE) + 1 || puck_x == int'(RIGHT_LINE) - 1)
                        dx = -dx;
                if (on_row && on_paddle) begin
                        paddle_hits++;
                        game_hits++;
                end
                missed = on_row && !on_paddle;
        endtask

        // the paddle chases the puck until it has returned it twice in a game
        // after that the keys are pure chance and the paddle drifts off the puck
        task automatic pick_keys();
                logic [1:0] keys;
                int         centre;
                keys   = 2'($urandom);
                centre = paddle_x + int'(PADDLE_WIDTH) / 2;
                if (game_hits < 2) begin
                        // KEY[1] stays random when going right because KEY[0] wins
                        if (puck_x > centre)
                                keys[0] = 1'b0;
                        else if (puck_x < centre)
                                keys = 2'b01;
                        else
                                keys = 2'b11;
                end
                KEY[1:0] = keys;
        endtask

        task automatic play_frame();
                queue_run(paddle_x, int'(PADDLE_ROW), 1'b0, paddle_x + int'(PADDLE_WIDTH), BLACK);
                wait_for_pixels("paddle erase");
                move_paddle_model();
                queue_run(paddle_x, int'(PADDLE_ROW), 1'b0, paddle_x + int'(PADDLE_WIDTH), RED);
                wait_for_pixels("paddle draw");
                // new keys hold until the next red paddle run
                pick_keys();
                step_puck_model();
                queue_run(prev_x, prev_y, 1'b0, prev_x, BLACK);
                wait_for_pixels("puck erase");
                frames++;
                if (missed) begin
                        // a lost puck restarts the game from a blank screen
                        misses++;
                        since_miss = 0;
                        reset_model();
                        draw_screen();
                end else begin
                        queue_run(puck_x, puck_y, 1'b0, puck_x, CYAN);
                        wait_for_pixels("puck draw");
                        since_miss++;
                end
        endtask

        // ====================================================================
        // main sequence
        // ====================================================================

        initial begin
                void'($urandom(84590));
                KEY         = 4'b0111;
                misses      = 0;
                since_miss  = 0;
                frames      = 0;
                paddle_hits = 0;
                right_stops = 0;
                left_stops  = 0;
                reset_model();
                repeat (2) @(negedge CLOCK_50);
                KEY[3] = 1'b1;
                draw_screen();
                // play until a miss has happened and the restarted game has run a while
                while (frames < MAX_FRAMES &&
                       !(frames >= MIN_FRAMES && misses > 0 && since_miss >= FRAMES_AFTER))
                        play_frame();
                if (misses == 0 || since_miss < FRAMES_AFTER || paddle_hits == 0 ||
                    right_stops == 0 || left_stops == 0) begin
                        stop_on_error({"play never showed a paddle bounce, ",
                                       "both paddle stops and a missed puck"});
                end else begin
                        $display("PASS: all tests");
                        $finish;
                end
        end

endmodule

//--- sim.f
logic/pong_pkg.sv
logic/frame_timer.sv
logic/pixel_walker.sv
logic/paddle_unit.sv
logic/puck_unit.sv
logic/draw_sequencer.sv
logic/pong_top.sv
bench/pong_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = pong_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard logic/*.sv bench/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
